/* logic/fdc_pkg.sv */
// Constants, types and command tables shared by the FDC emulator
// Only Specify, Read Data and Write Data decode; sectors are 16 bytes
`default_nettype none

package fdc_pkg;

	localparam int SECTOR_BYTES = 16;	// Emulated sector length
	localparam int DCNT_W = $clog2(SECTOR_BYTES);
	localparam int FIFO_AW = 4;	// Exactly one sector per FIFO
	localparam logic [7:0] SIZE_CODE = 8'd2;	// N reported in results
	localparam logic [7:0] FILL_BYTE_RESET = 8'hE5;

	// Low five bits of the command byte
	localparam logic [4:0] OP_SPECIFY = 5'h03;
	localparam logic [4:0] OP_WRITE_DATA = 5'h05;
	localparam logic [4:0] OP_READ_DATA = 5'h06;

	localparam logic [3:0] SUP_FIFO_ADDR = 4'd0;	// Support side sector data port

	typedef logic [3:0] reg_idx_t;

	// Register map, shared by both read ports and the slot tables
	localparam reg_idx_t REG_SIZE = 4'd0;
	localparam reg_idx_t REG_SUP_STATUS = 4'd1;
	localparam reg_idx_t REG_HU = 4'd2;
	localparam reg_idx_t REG_HD = 4'd3;
	localparam reg_idx_t REG_TR = 4'd4;
	localparam reg_idx_t REG_SC = 4'd5;
	localparam reg_idx_t REG_LS = 4'd6;
	localparam reg_idx_t REG_FB = 4'd7;
	localparam reg_idx_t REG_S0 = 4'd8;
	localparam reg_idx_t REG_S1 = 4'd9;
	localparam reg_idx_t REG_S2 = 4'd10;
	localparam reg_idx_t REG_NM = 4'd12;
	localparam reg_idx_t REG_TP = 4'd13;
	localparam reg_idx_t REG_HRESULT = 4'd14;
	localparam reg_idx_t REG_NONE = 4'd15;	// Skip slot

	// Parameter and result byte orderings
	localparam logic [1:0] PP_NONE = 2'd0;
	localparam logic [1:0] PP_RW = 2'd1;
	localparam logic [1:0] RP_RW = 2'd0;
	localparam logic [1:0] RP_INVALID = 2'd1;

	typedef enum logic [2:0] {
		IDLE,
		PARAM,
		WAIT_SUP,	// Rendezvous with support CPU
		EXEC,
		PRERESULT,
		RESULT
	} fdc_state_e;

	typedef struct packed {
		logic invalid;
		logic [3:0] param_count;
		logic is_read;
		logic is_write;
		logic [2:0] result_count;
		logic repeats;	// Ends "not terminated"
		logic [1:0] param_pattern;
		logic [1:0] result_pattern;
	} cmd_attr_t;

	typedef struct packed {
		logic sel;	// 0 status, 1 data
		logic rd;
		logic wr;
		logic [7:0] data;
	} host_bus_t;

	typedef struct packed {
		logic [3:0] addr;
		logic rd;
		logic wr;
		logic [7:0] data;
	} sup_bus_t;

	function automatic cmd_attr_t cmd_decode(input logic [4:0] op);
		cmd_attr_t a;
		a = '0;
		case (op)
			OP_SPECIFY:
			begin
				a.param_count = 4'd2;	// SRT/HUT and HLT/ND, thrown away
				a.param_pattern = PP_NONE;
			end
			OP_READ_DATA, OP_WRITE_DATA:
			begin
				a.param_count = 4'd8;
				a.is_read = (op == OP_READ_DATA);
				a.is_write = (op == OP_WRITE_DATA);
				a.result_count = 3'd7;
				a.repeats = 1'b1;	// No EOT stop, so always unterminated
				a.param_pattern = PP_RW;
				a.result_pattern = RP_RW;
			end
			default:
			begin
				a.invalid = 1'b1;
				a.result_count = 3'd1;	// S0 only
				a.result_pattern = RP_INVALID;
			end
		endcase
		return a;
	endfunction

	function automatic reg_idx_t param_slot(input logic [1:0] ptn, input logic [2:0] pos);
		reg_idx_t idx;
		idx = REG_NONE;
		if (ptn == PP_RW)
		begin
			case (pos)
				3'd0: idx = REG_HU;
				3'd1: idx = REG_TR;
				3'd2: idx = REG_HD;
				3'd3: idx = REG_SC;
				3'd5: idx = REG_LS;
				default: idx = REG_NONE;	// N, GPL, DTL ignored
			endcase
		end
		return idx;
	endfunction

	function automatic reg_idx_t result_slot(input logic [1:0] ptn, input logic [2:0] pos);
		reg_idx_t idx;
		idx = REG_NONE;
		case (ptn)
			RP_RW:
			begin
				case (pos)
					3'd0: idx = REG_S0;
					3'd1: idx = REG_S1;
					3'd2: idx = REG_S2;
					3'd3: idx = REG_TR;
					3'd4: idx = REG_HD;
					3'd5: idx = REG_LS;
					3'd6: idx = REG_SIZE;
					default: idx = REG_NONE;
				endcase
			end
			RP_INVALID: idx = (pos == 3'd0) ? REG_S0 : REG_NONE;
			default: idx = REG_NONE;
		endcase
		return idx;
	endfunction

endpackage

`default_nettype wire

/* logic/fdc_byte_fifo.sv */
// Show-ahead byte FIFO, head byte valid whenever not empty
// Push when full and pop when empty are dropped
`timescale 1ns/1ps
`default_nettype none

module fdc_byte_fifo
	import fdc_pkg::*;
#(
	parameter int DEPTH_AW = FIFO_AW
)
(
	input logic sup_clk_i,
	input logic reset_i,
	input logic flush_i,	// Empties like reset
	input logic push_i,
	input logic [7:0] din_i,
	input logic pop_i,
	output logic [7:0] dout_o,
	output logic empty_o,
	output logic full_o
);

	logic [7:0] mem [2**DEPTH_AW];
	logic [DEPTH_AW-1:0] wr_ptr;
	logic [DEPTH_AW-1:0] rd_ptr;
	logic [DEPTH_AW:0] count;	// One extra bit for full
	logic do_push;
	logic do_pop;

	assign empty_o = (count == '0);
	assign full_o = (count == (DEPTH_AW+1)'(2**DEPTH_AW));
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;
	assign dout_o = mem[rd_ptr];	// Head visible without a pop

	always_ff @(posedge sup_clk_i)
	begin
		if (do_push)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i || flush_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps round the buffer
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/fdc_reg_file.sv */
// Controller registers, status build and two indexed read ports
// Index 0 is the fixed size code, unmapped indices read 0xFF
`timescale 1ns/1ps
`default_nettype none

module fdc_reg_file
	import fdc_pkg::*;
(
	input logic sup_clk_i,
	input logic reset_i,
	input logic param_we_i,
	input reg_idx_t param_idx_i,
	input logic [7:0] param_data_i,
	input logic hresult_we_i,	// From support CPU
	input logic [7:0] hresult_data_i,
	input logic status_load_i,	// One pulse in PRERESULT
	input cmd_attr_t status_attr_i,
	input reg_idx_t host_idx_i,
	input reg_idx_t sup_idx_i,
	input logic [7:0] sup_status_i,
	output logic [7:0] host_rdata_o,
	output logic [7:0] sup_rdata_o
);

	logic [7:0] hu, hd, tr, sc, ls, fb, nm, tp;
	logic [7:0] hresult;
	logic [7:0] s0, s1, s2;
	logic [1:0] s0_ic;	// Interrupt code field of S0

	// First match wins
	always_comb
	begin
		if (status_attr_i.invalid)
			s0_ic = 2'b10;
		else if (hresult[0])
			s0_ic = 2'b11;	// Drive not ready
		else if (status_attr_i.repeats)
			s0_ic = 2'b01;	// Normal for a CPC read
		else
			s0_ic = 2'b00;
	end

	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i)
		begin
			hu <= '0;
			hd <= '0;
			tr <= '0;
			sc <= '0;
			ls <= '0;
			fb <= FILL_BYTE_RESET;
			nm <= '0;
			tp <= '0;
			hresult <= '0;
			s0 <= '0;
			s1 <= '0;
			s2 <= '0;
		end
		else
		begin
			if (param_we_i)
			begin
				case (param_idx_i)
					REG_HU: hu <= param_data_i;
					REG_HD: hd <= param_data_i;
					REG_TR: tr <= param_data_i;
					REG_SC: sc <= param_data_i;
					REG_LS: ls <= param_data_i;
					REG_FB: fb <= param_data_i;
					REG_NM: nm <= param_data_i;
					REG_TP: tp <= param_data_i;
					default: ;	// Skip slot and read-only entries
				endcase
			end
			if (hresult_we_i)
				hresult <= hresult_data_i;
			if (status_load_i)
			begin
				// IC, no seek end, equip check, not ready, head and unit
				s0 <= {s0_ic, 1'b0, hresult[1], hresult[0], hu[2:0]};
				// EOT on any transfer, then write protect and no data
				s1 <= {status_attr_i.is_read | status_attr_i.is_write, 5'd0,
					hresult[3], hresult[2]};
				s2 <= 8'h00;
			end
		end
	end

	function automatic logic [7:0] reg_read(input reg_idx_t idx);
		case (idx)
			REG_SIZE: return SIZE_CODE;
			REG_SUP_STATUS: return sup_status_i;
			REG_HU: return hu;
			REG_HD: return hd;
			REG_TR: return tr;
			REG_SC: return sc;
			REG_LS: return ls;
			REG_FB: return fb;
			REG_S0: return s0;
			REG_S1: return s1;
			REG_S2: return s2;
			REG_NM: return nm;
			REG_TP: return tp;
			REG_HRESULT: return hresult;
			default: return 8'hFF;	// Includes old S3 slot
		endcase
	endfunction

	always_comb
	begin
		host_rdata_o = reg_read(host_idx_i);	// Result phase
		sup_rdata_o = reg_read(sup_idx_i);
	end

endmodule

`default_nettype wire

/* logic/fdc_sup_port.sv */
// Support CPU register port, strobes are single cycle
// The wait toggle request reaches the controller one cycle after the write
`timescale 1ns/1ps
`default_nettype none

module fdc_sup_port
	import fdc_pkg::*;
(
	input logic sup_clk_i,
	input sup_bus_t sup_bus_i,
	input logic [7:0] reg_rdata_i,
	input logic [7:0] c2s_head_i,	// Host-written sector data
	input logic motor_i,
	input logic should_wait_i,
	input logic [4:0] opcode_i,
	input logic skip_i,
	output logic [7:0] sup_rdata_o,
	output reg_idx_t reg_idx_o,
	output logic [7:0] sup_status_o,
	output logic s2c_push_o,
	output logic c2s_pop_o,
	output logic hresult_we_o,
	output logic sup_toggle_o
);

	logic fifo_sel;
	logic toggle_req;

	assign fifo_sel = (sup_bus_i.addr == SUP_FIFO_ADDR);

	// Status seen by drive firmware at address 1
	assign sup_status_o = {motor_i, should_wait_i, skip_i, opcode_i};

	// Register file decodes all non-FIFO addresses
	assign reg_idx_o = sup_bus_i.addr;
	assign sup_rdata_o = fifo_sel ? c2s_head_i : reg_rdata_i;

	assign s2c_push_o = sup_bus_i.wr && fifo_sel;
	assign c2s_pop_o = sup_bus_i.rd && fifo_sel;	// Read consumes head
	assign hresult_we_o = sup_bus_i.wr && (sup_bus_i.addr == REG_HRESULT);

	// Bit 0 set at address 1 asks to release the host
	assign toggle_req = sup_bus_i.wr && (sup_bus_i.addr == REG_SUP_STATUS)
		&& sup_bus_i.data[0];

	always_ff @(posedge sup_clk_i)
	begin
		sup_toggle_o <= toggle_req;
	end

endmodule

`default_nettype wire

/* logic/fdc_cmd_ctrl.sv */
// Command FSM for the host side, no back-pressure on data strobes
// Empty FIFO reads return 0xFF and still count toward the sector
`timescale 1ns/1ps
`default_nettype none

module fdc_cmd_ctrl
	import fdc_pkg::*;
(
	input logic sup_clk_i,
	input logic reset_i,
	input host_bus_t host_bus_i,
	input logic sup_toggle_i,
	input logic [7:0] s2c_head_i,
	input logic s2c_empty_i,
	input logic [7:0] reg_rdata_i,	// Selected by result_idx_o
	output logic [7:0] host_data_o,
	output logic activity_o,
	output logic should_wait_o,
	output logic [4:0] opcode_o,
	output logic skip_o,
	output logic flush_o,
	output logic s2c_pop_o,
	output logic c2s_push_o,
	output logic [7:0] c2s_data_o,
	output logic param_we_o,
	output reg_idx_t param_idx_o,
	output logic [7:0] param_data_o,
	output logic status_load_o,
	output cmd_attr_t attr_o,
	output reg_idx_t result_idx_o
);

	fdc_state_e state;
	cmd_attr_t attr;	// Latched at opcode write
	cmd_attr_t attr_new;
	logic [4:0] opcode;
	logic skip;
	logic [3:0] cnt;	// Parameter or result position
	logic [DCNT_W-1:0] data_cnt;
	logic host_flag;	// Toggled by controller
	logic sup_flag;	// Toggled by support CPU
	logic should_wait;
	logic data_rd, data_wr, data_stb;
	logic last_param, last_result, last_data;
	logic [7:0] main_status;

	assign should_wait = (host_flag != sup_flag);
	assign attr_new = cmd_decode(host_bus_i.data[4:0]);

	assign data_rd = host_bus_i.rd && host_bus_i.sel;
	assign data_wr = host_bus_i.wr && host_bus_i.sel;
	assign data_stb = attr.is_read ? data_rd : data_wr;	// Direction of transfer

	assign last_param = (cnt == attr.param_count - 4'd1);
	assign last_result = (cnt == {1'b0, attr.result_count} - 4'd1);
	assign last_data = (data_cnt == DCNT_W'(SECTOR_BYTES - 1));

	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i)
		begin
			state <= IDLE;
			attr <= '0;
			opcode <= '0;
			skip <= 1'b0;
			cnt <= '0;
			data_cnt <= '0;
			host_flag <= 1'b0;
			sup_flag <= 1'b0;
		end
		else
		begin
			// Support may only release a pending wait
			if (sup_toggle_i && should_wait)
				sup_flag <= ~sup_flag;

			case (state)
				IDLE:
				begin
					if (data_wr)
					begin
						attr <= attr_new;
						opcode <= host_bus_i.data[4:0];
						skip <= host_bus_i.data[5];	// SK bit
						cnt <= '0;
						if (attr_new.invalid || attr_new.param_count == 4'd0)
							state <= PRERESULT;
						else
							state <= PARAM;
					end
				end
				PARAM:
				begin
					if (data_wr)
					begin
						if (last_param)
						begin
							if (attr.is_read)
							begin
								host_flag <= ~host_flag;	// Ask drive for the sector
								state <= WAIT_SUP;
							end
							else if (attr.is_write)
								state <= EXEC;
							else
								state <= PRERESULT;	// Specify
						end
						else
							cnt <= cnt + 4'd1;
					end
				end
				WAIT_SUP:
				begin
					if (!should_wait)
						state <= attr.is_read ? EXEC : PRERESULT;
				end
				EXEC:
				begin
					if (data_stb)
					begin
						data_cnt <= last_data ? '0 : data_cnt + 1'b1;
						if (last_data)
						begin
							if (attr.is_write)
							begin
								host_flag <= ~host_flag;	// Hand sector to drive
								state <= WAIT_SUP;
							end
							else
								state <= PRERESULT;
						end
					end
				end
				PRERESULT:
				begin
					cnt <= '0;	// S0..S2 load this cycle
					state <= (attr.result_count != 3'd0) ? RESULT : IDLE;
				end
				RESULT:
				begin
					if (data_rd)
					begin
						if (last_result)
							state <= IDLE;
						else
							cnt <= cnt + 4'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// RQM, DIO, EXM, CB, drive busy bits unused
	assign main_status = {
		(state == IDLE) || (state == PARAM) || (state == EXEC) || (state == RESULT),
		(state == RESULT) || ((state == EXEC) && attr.is_read),
		(state == EXEC),
		(state != IDLE),
		4'b0000
	};

	always_comb
	begin
		if (!host_bus_i.sel)
			host_data_o = main_status;
		else if (state == EXEC && attr.is_read)
			host_data_o = s2c_empty_i ? 8'hFF : s2c_head_i;	// Underrun reads 0xFF
		else if (state == RESULT)
			host_data_o = reg_rdata_i;
		else
			host_data_o = 8'hFF;
	end

	assign activity_o = (state == WAIT_SUP) && should_wait;
	assign should_wait_o = should_wait;
	assign opcode_o = opcode;
	assign skip_o = skip;
	assign flush_o = (state == IDLE);	// Both FIFOs start each command empty

	assign s2c_pop_o = (state == EXEC) && attr.is_read && data_rd;
	assign c2s_push_o = (state == EXEC) && attr.is_write && data_wr;
	assign c2s_data_o = host_bus_i.data;

	assign param_we_o = (state == PARAM) && data_wr;
	assign param_idx_o = param_slot(attr.param_pattern, cnt[2:0]);
	assign param_data_o = host_bus_i.data;

	assign status_load_o = (state == PRERESULT);
	assign attr_o = attr;
	assign result_idx_o = result_slot(attr.result_pattern, cnt[2:0]);

endmodule

`default_nettype wire

/* logic/fdc_top.sv */
// FDC emulator top, single clock, host and support buses are strobe based
// Full flags and the c2s empty flag are not used by the controller
`timescale 1ns/1ps
`default_nettype none

module fdc_top
	import fdc_pkg::*;
(
	input logic sup_clk_i,
	input logic reset_i,
	input host_bus_t host_bus_i,
	input sup_bus_t sup_bus_i,
	input logic motor_i,
	output logic [7:0] host_data_o,
	output logic activity_o,
	output logic [7:0] sup_data_o
);

	logic should_wait;
	logic [4:0] opcode;
	logic skip;
	logic flush;
	logic s2c_pop, s2c_push, s2c_empty;
	logic [7:0] s2c_head;
	logic c2s_push, c2s_pop;
	logic [7:0] c2s_data, c2s_head;
	logic param_we;
	reg_idx_t param_idx;
	logic [7:0] param_data;
	logic status_load;
	cmd_attr_t attr;
	reg_idx_t result_idx, sup_idx;
	logic [7:0] host_rdata, sup_rdata;
	logic [7:0] sup_status;
	logic hresult_we;
	logic sup_toggle;

	fdc_cmd_ctrl fdc_cmd_ctrl_i (
		.sup_clk_i(sup_clk_i),
		.reset_i(reset_i),
		.host_bus_i(host_bus_i),
		.sup_toggle_i(sup_toggle),
		.s2c_head_i(s2c_head),
		.s2c_empty_i(s2c_empty),
		.reg_rdata_i(host_rdata),
		.host_data_o(host_data_o),
		.activity_o(activity_o),
		.should_wait_o(should_wait),
		.opcode_o(opcode),
		.skip_o(skip),
		.flush_o(flush),
		.s2c_pop_o(s2c_pop),
		.c2s_push_o(c2s_push),
		.c2s_data_o(c2s_data),
		.param_we_o(param_we),
		.param_idx_o(param_idx),
		.param_data_o(param_data),
		.status_load_o(status_load),
		.attr_o(attr),
		.result_idx_o(result_idx)
	);

	fdc_reg_file fdc_reg_file_i (
		.sup_clk_i(sup_clk_i),
		.reset_i(reset_i),
		.param_we_i(param_we),
		.param_idx_i(param_idx),
		.param_data_i(param_data),
		.hresult_we_i(hresult_we),
		.hresult_data_i(sup_bus_i.data),
		.status_load_i(status_load),
		.status_attr_i(attr),
		.host_idx_i(result_idx),
		.sup_idx_i(sup_idx),
		.sup_status_i(sup_status),
		.host_rdata_o(host_rdata),
		.sup_rdata_o(sup_rdata)
	);

	fdc_sup_port fdc_sup_port_i (
		.sup_clk_i(sup_clk_i),
		.sup_bus_i(sup_bus_i),
		.reg_rdata_i(sup_rdata),
		.c2s_head_i(c2s_head),
		.motor_i(motor_i),
		.should_wait_i(should_wait),
		.opcode_i(opcode),
		.skip_i(skip),
		.sup_rdata_o(sup_data_o),
		.reg_idx_o(sup_idx),
		.sup_status_o(sup_status),
		.s2c_push_o(s2c_push),
		.c2s_pop_o(c2s_pop),
		.hresult_we_o(hresult_we),
		.sup_toggle_o(sup_toggle)
	);

	// Drive to host, read sector data
	fdc_byte_fifo #(.DEPTH_AW(FIFO_AW)) s2c_fifo_i (
		.sup_clk_i(sup_clk_i),
		.reset_i(reset_i),
		.flush_i(flush),
		.push_i(s2c_push),
		.din_i(sup_bus_i.data),
		.pop_i(s2c_pop),
		.dout_o(s2c_head),
		.empty_o(s2c_empty),
		.full_o()
	);

	// Host to drive, write sector data
	fdc_byte_fifo #(.DEPTH_AW(FIFO_AW)) c2s_fifo_i (
		.sup_clk_i(sup_clk_i),
		.reset_i(reset_i),
		.flush_i(flush),
		.push_i(c2s_push),
		.din_i(c2s_data),
		.pop_i(c2s_pop),
		.dout_o(c2s_head),
		.empty_o(),
		.full_o()
	);

endmodule

`default_nettype wire

/* verification/fdc_chk.sv */
// Concurrent checks on the command FSM, bound into fdc_cmd_ctrl
// All checks are off while reset is high
`timescale 1ns/1ps
`default_nettype none

module fdc_chk
	import fdc_pkg::*;
(
	input logic sup_clk_i,
	input logic reset_i,
	input fdc_state_e state_i,
	input logic flush_i,
	input logic activity_i,
	input logic s2c_empty_i
);

	// FIFOs only emptied between commands, flushed FIFO reads empty next cycle
	flush_idle_a: assert property (@(posedge sup_clk_i) disable iff (reset_i)
		flush_i |=> s2c_empty_i)
		else $error("s2c FIFO not empty after flush");

	// Host flag toggles on entry, so the rendezvous starts with activity
	activity_wait_a: assert property (@(posedge sup_clk_i) disable iff (reset_i)
		$rose(state_i == WAIT_SUP) |-> activity_i)
		else $error("WAIT_SUP entered without activity");

	// Status load is a single cycle
	preresult_once_a: assert property (@(posedge sup_clk_i) disable iff (reset_i)
		(state_i == PRERESULT) |=> (state_i != PRERESULT))
		else $error("PRERESULT held longer than one cycle");

endmodule

bind fdc_cmd_ctrl fdc_chk fdc_chk_i (
	.sup_clk_i(sup_clk_i),
	.reset_i(reset_i),
	.state_i(state),
	.flush_i(flush_o),
	.activity_i(activity_o),
	.s2c_empty_i(s2c_empty_i)
);

`default_nettype wire

/* verification/tb_fdc.sv */
// Random command mix against a register model, one command at a time
// Host and support strobes are one cycle wide, driven 2 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_fdc
	import fdc_pkg::*;
();

	localparam int NUM_CMDS = 24;
	localparam int CYCLE_LIMIT = NUM_CMDS * 400;	// A read or write takes under 150
	localparam int SEED = 32'h43c7;

	logic sup_clk;
	logic reset;
	host_bus_t host_bus;
	sup_bus_t sup_bus;
	logic motor;
	logic [7:0] host_data;
	logic activity;
	logic [7:0] sup_data;

	// Model copies of the registers that come back in results
	logic [7:0] m_hu, m_tr, m_hd, m_ls;
	logic [7:0] m_hres;	// Last drive result
	logic [7:0] sector [SECTOR_BYTES];
	int cycles = 0;
	int err_cnt;
	int seed_ret;

	fdc_top fdc_top_i (
		.sup_clk_i(sup_clk),
		.reset_i(reset),
		.host_bus_i(host_bus),
		.sup_bus_i(sup_bus),
		.motor_i(motor),
		.host_data_o(host_data),
		.activity_o(activity),
		.sup_data_o(sup_data)
	);

	initial
	begin
		sup_clk = 1'b0;
		forever #10 sup_clk = ~sup_clk;
	end

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first failure");
	endtask

	always @(posedge sup_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the DUT never finished a command", cycles);
			stop_run();
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		assert (got === want)
		else
		begin
			err_cnt++;
			$display("Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, want);
			stop_run();
		end
	endtask

	// Entry and exit at 2 ns past a rising edge, strobes low
	task automatic host_write(input logic [7:0] d);
		host_bus.sel = 1'b1;
		host_bus.wr = 1'b1;
		host_bus.data = d;
		@(posedge sup_clk);
		#2;
		host_bus.wr = 1'b0;
	endtask

	task automatic host_read(input logic sel, output logic [7:0] d);
		host_bus.sel = sel;	// 0 status, 1 data
		host_bus.rd = 1'b1;
		@(negedge sup_clk);
		d = host_data;	// Value before the strobe takes effect
		@(posedge sup_clk);
		#2;
		host_bus.rd = 1'b0;
	endtask

	task automatic sup_write(input logic [3:0] addr, input logic [7:0] d);
		sup_bus.addr = addr;
		sup_bus.wr = 1'b1;
		sup_bus.data = d;
		@(posedge sup_clk);
		#2;
		sup_bus.wr = 1'b0;
	endtask

	task automatic sup_read(input logic [3:0] addr, output logic [7:0] d);
		sup_bus.addr = addr;
		sup_bus.rd = 1'b1;
		@(negedge sup_clk);
		d = sup_data;
		@(posedge sup_clk);
		#2;
		sup_bus.rd = 1'b0;
	endtask

	task automatic wait_rqm(output logic [7:0] st);
		do
			host_read(1'b0, st);
		while (!st[7]);	// Hang guarded by cycle limit
	endtask

	// S0 from the status rules, R/W commands always repeat
	function automatic logic [7:0] model_s0(input logic invalid);
		logic [1:0] ic;
		if (invalid)
			ic = 2'b10;
		else if (m_hres[0])
			ic = 2'b11;
		else
			ic = 2'b01;
		return {ic, 1'b0, m_hres[1], m_hres[0], m_hu[2:0]};
	endfunction

	task automatic send_rw_params();
		logic [7:0] p [8];
		logic [7:0] st;
		foreach (p[i])
			p[i] = 8'($urandom);
		for (int i = 0; i < 8; i++)
		begin
			host_read(1'b0, st);
			check_byte("main status in PARAM", st, 8'h90);
			host_write(p[i]);
		end
		m_hu = p[0];	// HU TR HD SC N LS GPL DTL
		m_tr = p[1];
		m_hd = p[2];
		m_ls = p[5];
	endtask

	task automatic check_sup_wait(input logic sk, input logic [4:0] op);
		logic [7:0] st;
		motor = 1'($urandom);	// Motor line as the drive sees it
		sup_read(REG_SUP_STATUS, st);
		check_byte("support status", st, {motor, 1'b1, sk, op});
		check_byte("activity_o in wait", {7'd0, activity}, 8'h01);
	endtask

	task automatic release_host();
		m_hres = 8'($urandom);
		sup_write(REG_HRESULT, m_hres);
		sup_write(REG_SUP_STATUS, 8'h01);	// Toggle support flag
	endtask

	task automatic check_rw_results();
		logic [7:0] want [7];
		logic [7:0] st;
		logic [7:0] d;
		want[0] = model_s0(1'b0);
		want[1] = {1'b1, 5'd0, m_hres[3], m_hres[2]};
		want[2] = 8'h00;
		want[3] = m_tr;
		want[4] = m_hd;
		want[5] = m_ls;
		want[6] = SIZE_CODE;
		wait_rqm(st);
		check_byte("main status in RESULT", st, 8'hD0);
		for (int k = 0; k < 7; k++)
		begin
			host_read(1'b1, d);
			check_byte($sformatf("result byte %0d", k), d, want[k]);
		end
		host_read(1'b0, st);
		check_byte("main status after results", st, 8'h80);
	endtask

	task automatic run_read();
		logic sk;
		logic [7:0] st;
		logic [7:0] d;
		sk = 1'($urandom);
		host_write({2'($urandom), sk, OP_READ_DATA});
		send_rw_params();
		check_sup_wait(sk, OP_READ_DATA);
		foreach (sector[i])
		begin
			sector[i] = 8'($urandom);
			sup_write(SUP_FIFO_ADDR, sector[i]);	// Drive supplies the sector
		end
		release_host();
		wait_rqm(st);
		for (int i = 0; i < SECTOR_BYTES; i++)
		begin
			host_read(1'b0, st);
			check_byte("main status in read EXEC", st, 8'hF0);
			host_read(1'b1, d);
			check_byte($sformatf("read byte %0d", i), d, sector[i]);
		end
		check_rw_results();
	endtask

	task automatic run_write();
		logic sk;
		logic [7:0] st;
		logic [7:0] d;
		sk = 1'($urandom);
		host_write({2'($urandom), sk, OP_WRITE_DATA});
		send_rw_params();
		for (int i = 0; i < SECTOR_BYTES; i++)
		begin
			host_read(1'b0, st);
			check_byte("main status in write EXEC", st, 8'hB0);
			sector[i] = 8'($urandom);
			host_write(sector[i]);
		end
		check_sup_wait(sk, OP_WRITE_DATA);
		for (int i = 0; i < SECTOR_BYTES; i++)
		begin
			sup_read(SUP_FIFO_ADDR, d);	// Pops c2s head
			check_byte($sformatf("written byte %0d", i), d, sector[i]);
		end
		release_host();
		check_rw_results();
	endtask

	task automatic run_specify();
		logic [7:0] st;
		host_write({3'($urandom), OP_SPECIFY});
		repeat (2)
		begin
			host_read(1'b0, st);
			check_byte("main status in Specify", st, 8'h90);
			host_write(8'($urandom));	// Timing values, discarded
		end
		wait_rqm(st);
		check_byte("main status after Specify", st, 8'h80);
	endtask

	task automatic run_invalid();
		logic [4:0] op;
		logic [7:0] st;
		logic [7:0] d;
		do
			op = 5'($urandom);
		while (op == OP_SPECIFY || op == OP_WRITE_DATA || op == OP_READ_DATA);
		host_write({3'($urandom), op});
		wait_rqm(st);
		check_byte("main status after invalid", st, 8'hD0);
		host_read(1'b1, d);
		check_byte("invalid S0", d, model_s0(1'b1));
		host_read(1'b0, st);
		check_byte("main status after invalid result", st, 8'h80);
	endtask

	initial
	begin
		int kind;
		logic [7:0] st;
		seed_ret = $urandom(SEED);
		reset = 1'b1;
		motor = 1'b1;
		host_bus = '0;
		sup_bus = '0;
		err_cnt = 0;
		m_hu = '0;
		m_tr = '0;
		m_hd = '0;
		m_ls = '0;
		m_hres = '0;
		repeat (3) @(posedge sup_clk);
		#2;
		reset = 1'b0;
		host_read(1'b0, st);
		check_byte("main status after reset", st, 8'h80);
		check_byte("activity_o after reset", {7'd0, activity}, 8'h00);
		for (int n = 0; n < NUM_CMDS; n++)
		begin
			kind = (n < 4) ? n : int'($urandom % 4);	// Each kind once, then random
			case (kind)
				0: run_specify();
				1: run_invalid();
				2: run_read();
				default: run_write();
			endcase
		end
		if (err_cnt == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			$display("%0d checks failed", err_cnt);
			stop_run();
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
logic/fdc_pkg.sv
logic/fdc_byte_fifo.sv
logic/fdc_reg_file.sv
logic/fdc_sup_port.sv
logic/fdc_cmd_ctrl.sv
logic/fdc_top.sv
verification/fdc_chk.sv
verification/tb_fdc.sv

/* Makefile */
# Verilator build and run for the FDC emulator testbench
VERILATOR ?= verilator
TOP ?= tb_fdc
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
PASS_MSG ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
